/* sim.f */
design/uartPkg.sv
design/uartTx.sv
design/uartRx.sv
design/bistCtrl.sv
design/uartBistTop.sv
tests/uartBistSva.sv
tests/uartBistTb.sv

/* Bender.yml */
package:
  name: uart_bist

sources:
  - design/uartPkg.sv
  - design/uartTx.sv
  - design/uartRx.sv
  - design/bistCtrl.sv
  - design/uartBistTop.sv
  - target: test
    files:
      - tests/uartBistSva.sv
      - tests/uartBistTb.sv

/* tests/uartBistTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the UART with self-test: transmit, receive,
// framing error, loopback self-test and start gating
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module uartBistTb;

	import uartPkg::*;

	// one 8N1 frame in clocks
	localparam int FrameClks = FrameBits * ClksPerBit;
	// about 12 frames of 80 clocks plus a 4 pattern self-test, with wide margin
	localparam int MaxCycles = 3000;
	// a self-test run is NumPatterns frames plus a few control cycles each
	localparam int BistWaitLimit = NumPatterns * (FrameClks + 8) + FrameClks;

	logic Clk;
	logic Rst;
	logic TxStart;
	dataT TxData;
	logic TxBusy;
	logic TxSerial;
	logic RxSerial;
	dataT RxData;
	logic RxValid;
	logic RxFrameError;
	logic BistStart;
	logic BistBusy;
	logic BistDone;
	logic BistError;

	int checkCount;
	int errorCount;
	int cycleCount;
	logic [31:0] lfsrState;
	// received bytes and frame error flags, captured on the falling edge
	dataT rxQ[$];
	logic feQ[$];

	uartBistTop dut
	(
		.Clk          (Clk),
		.Rst          (Rst),
		.TxStart      (TxStart),
		.TxData       (TxData),
		.TxBusy       (TxBusy),
		.TxSerial     (TxSerial),
		.RxSerial     (RxSerial),
		.RxData       (RxData),
		.RxValid      (RxValid),
		.RxFrameError (RxFrameError),
		.BistStart    (BistStart),
		.BistBusy     (BistBusy),
		.BistDone     (BistDone),
		.BistError    (BistError)
	);

	// period of 4
	always #2 Clk = ~Clk;

	// receive monitor, outputs are settled at the falling edge
	always @(negedge Clk)
	begin
		if (!Rst && RxValid)
		begin
			rxQ.push_back(RxData);
			feQ.push_back(RxFrameError);
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one step per bit taken
	function automatic dataT randomByte();
		dataT b;
		b = '0;
		for (int i = 0; i < 8; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			b = {lfsrState[0], b[7:1]};
		end
		return b;
	endfunction

	// drive point, 1 unit after the rising edge
	task automatic waitCycle();
		@(posedge Clk);
		#1;
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checkCount++;
		assert (got === exp)
		else
		begin
			errorCount++;
			$display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		checkCount++;
		assert (cond === 1'b1)
		else
		begin
			errorCount++;
			$display("%s", what);
		end
	endtask

	// 8N1 frame on RxSerial, then one idle bit
	task automatic sendFrame(input dataT b, input logic stopBit);
		RxSerial = 1'b0;
		repeat (ClksPerBit) waitCycle();
		for (int i = 0; i < 8; i++)
		begin
			RxSerial = b[i];
			repeat (ClksPerBit) waitCycle();
		end
		RxSerial = stopBit;
		repeat (ClksPerBit) waitCycle();
		RxSerial = 1'b1;
		repeat (ClksPerBit) waitCycle();
	endtask

	task automatic waitForRx(input int count);
		int n;
		n = 0;
		while (rxQ.size() < count && n < 2 * FrameClks)
		begin
			waitCycle();
			n++;
		end
		checkTrue(rxQ.size() >= count, "RxValid did not arrive in time");
	endtask

	task automatic waitForBistDone();
		int n;
		n = 0;
		while (!BistDone && n < BistWaitLimit)
		begin
			waitCycle();
			n++;
		end
		checkTrue(BistDone, "BistDone did not arrive in time");
	endtask

	// the four loopback bytes in list order and nothing else
	task automatic checkPatterns();
		checkValue("RxValid count", rxQ.size(), NumPatterns);
		for (int i = 0; i < NumPatterns && i < rxQ.size(); i++)
			checkValue("RxData", rxQ[i], BistPattern[i]);
	endtask

	task automatic transmitTest();
		dataT b;
		int n;
		for (int f = 0; f < 3; f++)
		begin
			b = randomByte();
			TxData = b;
			TxStart = 1'b1;
			waitCycle();
			TxStart = 1'b0;
			n = 0;
			while (TxSerial && n < FrameClks)
			begin
				waitCycle();
				n++;
			end
			checkTrue(!TxSerial, "no start bit seen on TxSerial");
			// middle of the start bit, then one bit period per step
			repeat (HalfBit) waitCycle();
			checkValue("TxSerial start bit", TxSerial, 1'b0);
			for (int i = 0; i < 8; i++)
			begin
				repeat (ClksPerBit) waitCycle();
				checkValue("TxSerial data bit", TxSerial, b[i]);
			end
			repeat (ClksPerBit) waitCycle();
			checkValue("TxSerial stop bit", TxSerial, 1'b1);
			n = 0;
			while (TxBusy && n < ClksPerBit)
			begin
				waitCycle();
				n++;
			end
			checkTrue(!TxBusy, "TxBusy did not fall after the stop bit");
		end
		$display("transmit test finished, %0d errors so far", errorCount);
	endtask

	task automatic receiveTest();
		dataT b;
		for (int f = 0; f < 3; f++)
		begin
			b = randomByte();
			rxQ.delete();
			feQ.delete();
			sendFrame(b, 1'b1);
			waitForRx(1);
			checkValue("RxValid count", rxQ.size(), 1);
			if (rxQ.size() > 0)
			begin
				checkValue("RxData", rxQ[0], b);
				checkValue("RxFrameError", feQ[0], 1'b0);
			end
		end
		$display("receive test finished, %0d errors so far", errorCount);
	endtask

	task automatic frameErrorTest();
		dataT b;
		b = randomByte();
		rxQ.delete();
		feQ.delete();
		// stop bit held low
		sendFrame(b, 1'b0);
		waitForRx(1);
		if (rxQ.size() > 0)
		begin
			checkValue("RxData", rxQ[0], b);
			checkValue("RxFrameError", feQ[0], 1'b1);
		end
		$display("framing error test finished, %0d errors so far", errorCount);
	endtask

	task automatic selfTestRun();
		rxQ.delete();
		feQ.delete();
		BistStart = 1'b1;
		waitCycle();
		BistStart = 1'b0;
		checkValue("BistBusy", BistBusy, 1'b1);
		waitForBistDone();
		checkValue("BistError", BistError, 1'b0);
		checkValue("BistBusy", BistBusy, 1'b0);
		checkPatterns();
		waitCycle();
		checkValue("TxBusy", TxBusy, 1'b0);
		$display("self-test finished, %0d errors so far", errorCount);
	endtask

	task automatic gatingTest();
		int n;
		rxQ.delete();
		feQ.delete();
		BistStart = 1'b1;
		waitCycle();
		BistStart = 1'b0;
		// user strobe while the controller sits in its setup cycle
		TxData = randomByte();
		TxStart = 1'b1;
		waitCycle();
		TxStart = 1'b0;
		waitForBistDone();
		repeat (2 * ClksPerBit) waitCycle();
		checkPatterns();
		checkValue("TxBusy", TxBusy, 1'b0);
		// self-test request in the middle of a user frame
		TxData = randomByte();
		TxStart = 1'b1;
		waitCycle();
		TxStart = 1'b0;
		repeat (3) waitCycle();
		BistStart = 1'b1;
		waitCycle();
		BistStart = 1'b0;
		n = 0;
		while (TxBusy && n < FrameClks)
		begin
			checkValue("BistBusy", BistBusy, 1'b0);
			waitCycle();
			n++;
		end
		checkTrue(!TxBusy, "user frame did not end");
		waitCycle();
		checkValue("BistBusy", BistBusy, 1'b0);
		$display("gating test finished, %0d errors so far", errorCount);
	endtask

	// run limit
	initial
	begin
		cycleCount = 0;
		while (cycleCount < MaxCycles)
		begin
			@(posedge Clk);
			cycleCount++;
		end
		$display("run stopped at the limit of %0d cycles", MaxCycles);
		$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		Clk = 1'b0;
		Rst = 1'b1;
		TxStart = 1'b0;
		TxData = '0;
		RxSerial = 1'b1;
		BistStart = 1'b0;
		checkCount = 0;
		errorCount = 0;
		lfsrState = 32'h7175;
		repeat (16) waitCycle();
		Rst = 1'b0;
		repeat (4) waitCycle();
		transmitTest();
		receiveTest();
		frameErrorTest();
		selfTestRun();
		gatingTest();
		// failures of the bound controller checker
		errorCount += dut.ctrl.sva.failCount;
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/uartBistSva.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound assertions on the self-test controller strobes and levels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module uartBistSva
(
	input wire                     Clk,
	input wire                     Rst,
	input wire uartPkg::bistStateT state,
	input wire                     TxGo,
	input wire                     TxBusy,
	input wire                     LoopMode,
	input wire                     BistDone
);

	import uartPkg::*;

	// failed checks, read by the testbench at the end of the run
	int failCount;

	// done is a single-cycle strobe
	doneOneCycle: assert property (@(posedge Clk) disable iff (Rst) BistDone |=> !BistDone)
		else
		begin
			failCount++;
			$error("BistDone held for more than one cycle");
		end

	// the transmitter never gets a start while a frame runs
	noGoWhileBusy: assert property (@(posedge Clk) disable iff (Rst) !(TxGo && TxBusy))
		else
		begin
			failCount++;
			$error("TxGo issued while TxBusy is high");
		end

	// receiver source switches only inside a run and with the transmit line idle
	loopSwitchIdle: assert property (@(posedge Clk) disable iff (Rst)
		$changed(LoopMode) |-> !TxBusy && (state != Ready))
		else
		begin
			failCount++;
			$error("LoopMode changed outside a run or while TxBusy is high");
		end

endmodule

// every controller instance gets the checks
bind bistCtrl uartBistSva sva
(
	.Clk      (Clk),
	.Rst      (Rst),
	.state    (state),
	.TxGo     (TxGo),
	.TxBusy   (TxBusy),
	.LoopMode (LoopMode),
	.BistDone (BistDone)
);

`default_nettype wire

/* design/uartBistTop.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART top, self-test controller with transmitter and receiver
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module uartBistTop
(
	input  wire            Clk,
	input  wire            Rst,
	input  wire            TxStart,
	input  wire uartPkg::dataT TxData,
	output logic           TxBusy,
	output logic           TxSerial,
	input  wire            RxSerial,
	output uartPkg::dataT  RxData,
	output logic           RxValid,
	output logic           RxFrameError,
	input  wire            BistStart,
	output logic           BistBusy,
	output logic           BistDone,
	output logic           BistError
);

	import uartPkg::*;

	// controller to transmitter
	logic txGo;
	dataT txByte;
	// transmitter line, also the loopback source
	logic txLine;
	logic txBusyInt;
	// receiver source select
	logic loopMode;
	// receiver results, shared by the user side and the controller
	dataT rxByte;
	logic rxStrobe;

	bistCtrl ctrl
	(
		.Clk       (Clk),
		.Rst       (Rst),
		.BistStart (BistStart),
		.UserStart (TxStart),
		.UserData  (TxData),
		.TxBusy    (txBusyInt),
		.RxData    (rxByte),
		.RxValid   (rxStrobe),
		.TxGo      (txGo),
		.TxByte    (txByte),
		.LoopMode  (loopMode),
		.BistBusy  (BistBusy),
		.BistDone  (BistDone),
		.BistError (BistError)
	);

	uartTx tx
	(
		.Clk  (Clk),
		.Rst  (Rst),
		.Go   (txGo),
		.Data (txByte),
		.Line (txLine),
		.Busy (txBusyInt)
	);

	uartRx rx
	(
		.Clk        (Clk),
		.Rst        (Rst),
		.Serial     (RxSerial),
		.LoopLine   (txLine),
		.LoopMode   (loopMode),
		.Data       (rxByte),
		.Valid      (rxStrobe),
		.FrameError (RxFrameError)
	);

	// transmit line stays visible during a self-test too
	assign TxSerial = txLine;
	assign TxBusy   = txBusyInt;
	assign RxData   = rxByte;
	assign RxValid  = rxStrobe;

endmodule

`default_nettype wire

/* design/bistCtrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// self-test controller, transmit source mux, pattern sequencing and the
// latched loopback compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module bistCtrl
(
	input  wire            Clk,
	input  wire            Rst,
	input  wire            BistStart,
	input  wire            UserStart,
	input  wire uartPkg::dataT UserData,
	input  wire            TxBusy,
	input  wire uartPkg::dataT RxData,
	input  wire            RxValid,
	output logic           TxGo,
	output uartPkg::dataT  TxByte,
	output logic           LoopMode,
	output logic           BistBusy,
	output logic           BistDone,
	output logic           BistError
);

	import uartPkg::*;

	bistStateT state;
	bistStateT nextState;

	// pattern in flight
	patIdxT patIdx;
	// sticky mismatch flag for the current run
	logic errQ;

	// self-test request, only taken with the transmitter idle
	logic bistAccept;
	// loopback byte back while waiting
	logic rxHit;
	logic lastPat;

	assign bistAccept = (state == Ready) && BistStart && !TxBusy;
	assign rxHit      = (state == Wait) && RxValid;
	assign lastPat    = (patIdx == patIdxT'(NumPatterns - 1));

	// state register
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
			state <= Ready;
		else
			state <= nextState;
	end

	// next state
	always_comb
	begin
		nextState = state;
		unique case (state)
			Ready:
				if (bistAccept)
					nextState = Active;
			Active:
				// one setup cycle while the receiver switches over
				nextState = Send;
			Send:
				// hold until the previous frame has left the line
				if (!TxBusy)
					nextState = Wait;
			Wait:
				if (RxValid)
					nextState = lastPat ? Done : Send;
			Done:
				nextState = Ready;
			default:
				nextState = Ready;
		endcase
	end

	// pattern index and error flag
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			patIdx <= '0;
			errQ   <= 1'b0;
		end
		else if (bistAccept)
		begin
			// fresh run
			patIdx <= '0;
			errQ   <= 1'b0;
		end
		else if (rxHit)
		begin
			// any miss sticks until the next accepted start
			errQ <= errQ | (RxData != BistPattern[patIdx]);
			if (!lastPat)
				patIdx <= patIdx + patIdxT'(1);
		end
	end

	// user data passes through in Ready, patterns otherwise
	assign TxByte = (state == Ready) ? UserData : BistPattern[patIdx];

	// one transmit strobe per pattern, user strobe only when the test is not starting
	always_comb
	begin
		TxGo = 1'b0;
		if (state == Ready)
			TxGo = UserStart && !BistStart && !TxBusy;
		else if (state == Send)
			TxGo = !TxBusy;
	end

	// state decoded outputs
	assign LoopMode  = (state == Active) || (state == Send) || (state == Wait);
	assign BistBusy  = LoopMode;
	assign BistDone  = (state == Done);
	assign BistError = errQ;

endmodule

`default_nettype wire

/* design/uartRx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 receiver with loopback source select, two-flop synchronizer,
// start edge detect, glitch reject and mid-bit sampling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module uartRx
(
	input  wire            Clk,
	input  wire            Rst,
	input  wire            Serial,
	input  wire            LoopLine,
	input  wire            LoopMode,
	output uartPkg::dataT  Data,
	output logic           Valid,
	output logic           FrameError
);

	import uartPkg::*;

	// selected line, asynchronous to Clk in normal mode
	logic srcLine;
	// sync[1] is the usable line, sync[2] its previous value
	logic [2:0] sync;
	logic rxBit;
	logic startEdge;

	// frame in progress
	logic active;
	// clocks since the last sample point
	clkCntT clkCnt;
	// 0 is the start check, 1..8 data, 9 stop
	bitCntT bitCnt;
	// sample this cycle
	logic sampleNow;
	// data bits collected so far, lsb arrives first
	dataT shiftReg;

	assign srcLine = LoopMode ? LoopLine : Serial;

	// idle high so reset does not look like a start edge
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
			sync <= '1;
		else
			sync <= {sync[1:0], srcLine};
	end

	assign rxBit = sync[1];
	// high to low on the synchronized line
	assign startEdge = sync[2] && !sync[1];

	// first sample is half a bit in, the rest a full bit apart
	assign sampleNow = (bitCnt == '0) ? (clkCnt == clkCntT'(HalfBit - 1))
		: (clkCnt == clkCntT'(ClksPerBit - 1));

	// frame sequencing and the output strobes
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			active     <= 1'b0;
			clkCnt     <= '0;
			bitCnt     <= '0;
			Valid      <= 1'b0;
			FrameError <= 1'b0;
		end
		else
		begin
			// strobes last one cycle
			Valid      <= 1'b0;
			FrameError <= 1'b0;
			if (!active)
			begin
				if (startEdge)
				begin
					active <= 1'b1;
					clkCnt <= '0;
					bitCnt <= '0;
				end
			end
			else if (sampleNow)
			begin
				clkCnt <= '0;
				if (bitCnt == '0)
				begin
					// start bit gone high again, treat as a glitch
					if (rxBit)
						active <= 1'b0;
					else
						bitCnt <= bitCntT'(1);
				end
				else if (bitCnt == bitCntT'(FrameBits - 1))
				begin
					// stop bit sampled, report next cycle
					active     <= 1'b0;
					Valid      <= 1'b1;
					FrameError <= !rxBit;
				end
				else
				begin
					bitCnt <= bitCnt + bitCntT'(1);
				end
			end
			else
			begin
				clkCnt <= clkCnt + clkCntT'(1);
			end
		end
	end

	// data bits shift in, the byte is held from the stop bit sample on
	always_ff @(posedge Clk)
	begin
		if (active && sampleNow)
		begin
			if (bitCnt == bitCntT'(FrameBits - 1))
				Data <= shiftReg;
			else if (bitCnt != '0)
				shiftReg <= {rxBit, shiftReg[7:1]};
		end
	end

endmodule

`default_nettype wire

/* design/uartTx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 serializer, one frame per accepted start strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module uartTx
(
	input  wire            Clk,
	input  wire            Rst,
	input  wire            Go,
	input  wire uartPkg::dataT Data,
	output logic           Line,
	output logic           Busy
);

	import uartPkg::*;

	// remaining frame, bit 0 is the bit on the line
	logic [FrameBits-1:0] frame;
	// clocks spent in the current bit
	clkCntT clkCnt;
	// index of the bit on the line, 0 is the start bit
	bitCntT bitCnt;

	logic bitEnd;
	logic lastBit;
	logic load;

	// a strobe only counts while idle
	assign load = Go && !Busy;

	// last clock of a bit period
	assign bitEnd = (clkCnt == clkCntT'(ClksPerBit - 1));

	// the stop bit is on the line
	assign lastBit = (bitCnt == bitCntT'(FrameBits - 1));

	// control path
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			Busy   <= 1'b0;
			clkCnt <= '0;
			bitCnt <= '0;
		end
		else if (load)
		begin
			// start bit goes out on this same edge
			Busy   <= 1'b1;
			clkCnt <= '0;
			bitCnt <= '0;
		end
		else if (Busy)
		begin
			if (bitEnd)
			begin
				clkCnt <= '0;
				if (lastBit)
				begin
					// stop bit done, frame complete
					Busy <= 1'b0;
				end
				else
				begin
					bitCnt <= bitCnt + bitCntT'(1);
				end
			end
			else
			begin
				clkCnt <= clkCnt + clkCntT'(1);
			end
		end
	end

	// frame shifter, loaded on an accepted start and stepped at each bit end
	always_ff @(posedge Clk)
	begin
		if (load)
		begin
			// stop, data lsb first, start
			frame <= {1'b1, Data, 1'b0};
		end
		else if (Busy && bitEnd)
		begin
			// shift in ones so the tail stays at mark level
			frame <= {1'b1, frame[FrameBits-1:1]};
		end
	end

	// mark level whenever no frame is running
	assign Line = Busy ? frame[0] : 1'b1;

endmodule

`default_nettype wire

/* design/uartPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types, 8N1 frame timing, self-test patterns and controller states
// for the UART with built-in self-test
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package uartPkg;

	// one character on the line
	typedef logic [7:0] dataT;

	// clocks per bit period
	localparam integer ClksPerBit = 8;
	// offset from the start edge to the first sample point
	localparam integer HalfBit = ClksPerBit / 2;
	// start bit, eight data bits, stop bit
	localparam integer FrameBits = 10;

	// bit position within a frame
	typedef logic [3:0] bitCntT;
	// clock count within one bit period, wide enough for ClksPerBit
	typedef logic [$clog2(ClksPerBit + 1) - 1:0] clkCntT;

	// self-test byte list, sent in order through the internal loopback
	localparam integer NumPatterns = 4;
	localparam dataT BistPattern [NumPatterns] = '{8'hAA, 8'h55, 8'h00, 8'hFF};

	// index into the pattern list
	typedef logic [1:0] patIdxT;

	// controller states
	typedef enum logic [2:0] {
		Ready,
		Active,
		Send,
		Wait,
		Done
	} bistStateT;

endpackage

`default_nettype wire
